// ==== tests/gain_input.txt ====
// Columns are kind, address or last flag, data word, expected value, all hex
// Kinds 1 set gain, 2 sample, 3 readback, 4 clear, 5 end of test
// Test 1 unity gain after reset
2 0 00010002 00010002
2 0 7FFF8000 7FFF8000
2 1 1234FEDC 1234FEDC
5 1 0 0
// Test 2 gains of 1024, -2048 and 3000
1 80 00000400 0
2 0 0064FFFD 0032FFFE
2 1 FFFF0007 FFFF0003
1 80 1234F800 0
2 0 0005FFF9 FFFB0007
2 1 80000000 7FFF0000
1 80 00000BB8 0
2 0 03E8FC18 05B8FA47
2 1 0001FFFF 0001FFFE
3 0 0 0000000000000BB8
5 2 0 0
// Test 3 saturation with large gains
1 80 00007FFF 0
2 0 4000C000 7FFF8000
2 0 0010FFF0 00FFFF00
2 1 80000041 8000040F
1 80 00008000 0
2 0 00010040 FFF0FC00
2 1 7FFF8000 80007FFF
5 3 0 0
// Test 4 ordering under back-pressure, gain of two
1 80 00001000 0
2 0 00010002 00020004
2 1 0003FFFF 0006FFFE
2 0 01000200 02000400
2 0 04000500 08000A00
2 1 1000F000 2000E000
2 1 01230456 024608AC
5 4 0 0
// Test 5 readback and address decode
3 0 0 0000000000001000
1 81 0000ABCD 0
3 0 0 0000000000001000
1 80 0000C000 0
3 0 0 FFFFFFFFFFFFC000
3 5 0 0BADC0DE0BADC0DE
5 5 0 0
// Test 6 clear with samples in flight
2 0 00020003 FFF0FFE8
2 0 00040005 FFE0FFD8
2 1 00060007 FFD0FFC8
4 0 0 0
3 0 0 FFFFFFFFFFFFC000
2 0 00010000 FFF80000
2 1 0010FFF0 FF800080
5 6 0 0

// ==== compile.f ====
rtl/gain_pkg.sv
rtl/gain_settings.sv
rtl/complex_scaler.sv
rtl/complex_clip.sv
rtl/digital_gain.sv
tests/tb_digital_gain.sv

// ==== Makefile ====
# Verilator simulation of the digital gain block

VERILATOR ?= verilator
TOP       ?= tb_digital_gain
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_digital_gain.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_digital_gain;

  import gain_pkg::*;

  localparam int MAX_RECS    = 64;
  localparam int CLEAR_WATCH = 8;
  localparam int IDLE_WATCH  = 4;

  // Record kinds in the data file
  localparam int KIND_SET    = 1;
  localparam int KIND_SAMPLE = 2;
  localparam int KIND_RB     = 3;
  localparam int KIND_CLEAR  = 4;
  localparam int KIND_END    = 5;

  logic                 ce_clk;
  logic                 i_rst;
  logic                 i_set_stb;
  logic [SR_ADDR_W-1:0] i_set_addr;
  logic [SR_DATA_W-1:0] i_set_data;
  logic [SR_ADDR_W-1:0] i_rb_addr;
  rb_t                  o_rb_data;
  logic                 i_clear;
  iq_t                  i_tdata;
  logic                 i_tlast;
  logic                 i_tvalid;
  logic                 o_tready;
  iq_t                  o_tdata;
  logic                 o_tlast;
  logic                 o_tvalid;
  logic                 i_tready;

  // Four words per record
  logic [63:0] recs [0:4*MAX_RECS-1];
  // Expected outputs in order with the last flag on top
  logic [32:0] expected_q [$];
  logic [32:0] want;

  int   n_recs        = 0;
  int   errors        = 0;
  int   errors_before = 0;
  int   checks        = 0;
  int   tests         = 0;
  int   seed          = 3273;
  logic recs_counted  = 1'b0;

  digital_gain UUT (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_rb_data  (o_rb_data),
    .i_clear    (i_clear),
    .i_tdata    (i_tdata),
    .i_tlast    (i_tlast),
    .i_tvalid   (i_tvalid),
    .o_tready   (o_tready),
    .o_tdata    (o_tdata),
    .o_tlast    (o_tlast),
    .o_tvalid   (o_tvalid),
    .i_tready   (i_tready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #4 ce_clk = ~ce_clk;
  end

  // Back-pressure that is high about 70 percent of cycles
  initial begin
    i_tready = 1'b0;
    forever begin
      @(posedge ce_clk);
      #1;
      i_tready = ({$random(seed)} % 100) < 70;
    end
  end

  ////////////////////
  // Checking
  ////////////////////

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("MISMATCH at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  // Outputs are stable here and a transfer happens at the next rising edge
  always @(negedge ce_clk) begin
    if (!i_rst && o_tvalid && i_tready) begin
      if (expected_q.size() == 0) begin
        errors++;
        $display("Unexpected output sample %h at %0t", o_tdata, $time);
      end else begin
        want = expected_q.pop_front();
        check("o_tdata", {32'd0, want[31:0]}, {32'd0, o_tdata});
        check("o_tlast", {63'd0, want[32]}, {63'd0, o_tlast});
      end
    end
  end

  // Output stream must stay empty for the given number of cycles
  task automatic watch_idle(input int cycles);
    repeat (cycles) begin
      @(negedge ce_clk);
      check("o_tvalid", 64'd0, {63'd0, o_tvalid});
    end
    @(posedge ce_clk);
    #1;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic apply_setting(input logic [SR_ADDR_W-1:0] addr,
                               input logic [SR_DATA_W-1:0] data);
    i_set_stb  = 1'b1;
    i_set_addr = addr;
    i_set_data = data;
    @(posedge ce_clk);
    #1;
    i_set_stb  = 1'b0;
  endtask

  task automatic send_sample(input logic last, input iq_t data, input iq_t result);
    logic taken;
    i_tdata  = data;
    i_tlast  = last;
    i_tvalid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge ce_clk);
      taken = o_tready;
      @(posedge ce_clk);
      #1;
    end
    i_tvalid = 1'b0;
    expected_q.push_back({last, result});
  endtask

  task automatic read_back(input logic [SR_ADDR_W-1:0] addr, input rb_t result);
    i_rb_addr = addr;
    @(posedge ce_clk);
    #1;
    check("o_rb_data", result, o_rb_data);
  endtask

  // Samples in flight are lost and nothing may come out afterwards
  task automatic pulse_clear();
    i_clear = 1'b1;
    @(posedge ce_clk);
    #1;
    i_clear = 1'b0;
    expected_q.delete();
    watch_idle(CLEAR_WATCH);
  endtask

  task automatic finish_test(input int num);
    while (expected_q.size() != 0) begin
      @(posedge ce_clk);
      #1;
    end
    // Nothing may follow the last expected sample
    watch_idle(IDLE_WATCH);
    tests++;
    $display("Test %0d finished with %0d errors", num, errors - errors_before);
    errors_before = errors;
  endtask

  initial begin
    int base;
    i_rst      = 1'b1;
    i_set_stb  = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_addr  = '0;
    i_clear    = 1'b0;
    i_tdata    = '0;
    i_tlast    = 1'b0;
    i_tvalid   = 1'b0;
    for (int k = 0; k < 4 * MAX_RECS; k++) begin
      recs[k] = '0;
    end
    $readmemh("tests/gain_input.txt", recs);
    while (n_recs < MAX_RECS && recs[4*n_recs] != 64'd0) begin
      n_recs++;
    end
    recs_counted = 1'b1;
    if (n_recs == 0) begin
      errors++;
      $display("The data file held no records");
    end

    repeat (2) @(posedge ce_clk);
    #1;
    i_rst = 1'b0;

    for (int r = 0; r < n_recs; r++) begin
      base = 4 * r;
      case (int'(recs[base]))
        KIND_SET:    apply_setting(recs[base+1][SR_ADDR_W-1:0], recs[base+2][SR_DATA_W-1:0]);
        KIND_SAMPLE: send_sample(recs[base+1][0], recs[base+2][31:0], recs[base+3][31:0]);
        KIND_RB:     read_back(recs[base+1][SR_ADDR_W-1:0], recs[base+3]);
        KIND_CLEAR:  pulse_clear();
        KIND_END:    finish_test(int'(recs[base+1]));
        default: begin
          errors++;
          $display("Unknown record kind %0h in record %0d", recs[base], r);
        end
      endcase
    end

    $display("Ran %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog with a budget of 20 cycles per record
  initial begin
    wait (recs_counted && n_recs > 0);
    repeat (20 * n_recs) @(posedge ce_clk);
    $display("Run timed out after %0d cycles with the DUT not responding", 20 * n_recs);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/digital_gain.sv ====
`timescale 1ns/100ps
`default_nettype none

module digital_gain (
  input  wire                              ce_clk,
  input  wire                              i_rst,
  // Settings bus
  input  wire                              i_set_stb,
  input  wire  [gain_pkg::SR_ADDR_W-1:0]   i_set_addr,
  input  wire  [gain_pkg::SR_DATA_W-1:0]   i_set_data,
  // Readback
  input  wire  [gain_pkg::SR_ADDR_W-1:0]   i_rb_addr,
  output gain_pkg::rb_t                    o_rb_data,
  // Flush of samples in flight
  input  wire                              i_clear,
  // Input stream
  input  wire gain_pkg::iq_t               i_tdata,
  input  wire                              i_tlast,
  input  wire                              i_tvalid,
  output logic                             o_tready,
  // Output stream
  output gain_pkg::iq_t                    o_tdata,
  output logic                             o_tlast,
  output logic                             o_tvalid,
  input  wire                              i_tready
);

  import gain_pkg::*;

  gain_t gain;
  logic  flush;

  // Scaler to clip stream
  prod_t mid_i_prod;
  prod_t mid_q_prod;
  logic  mid_tlast;
  logic  mid_tvalid;
  logic  mid_tready;

  // Clear empties the datapath but keeps the gain
  assign flush = i_rst || i_clear;

  gain_settings u_settings (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_set_stb  (i_set_stb),
    .i_set_addr (i_set_addr),
    .i_set_data (i_set_data),
    .i_rb_addr  (i_rb_addr),
    .o_gain     (gain),
    .o_rb_data  (o_rb_data)
  );

  complex_scaler u_scaler (
    .ce_clk   (ce_clk),
    .i_rst    (flush),
    .i_gain   (gain),
    .i_tdata  (i_tdata),
    .i_tlast  (i_tlast),
    .i_tvalid (i_tvalid),
    .o_tready (o_tready),
    .o_i_prod (mid_i_prod),
    .o_q_prod (mid_q_prod),
    .o_tlast  (mid_tlast),
    .o_tvalid (mid_tvalid),
    .i_tready (mid_tready)
  );

  complex_clip u_clip (
    .ce_clk   (ce_clk),
    .i_rst    (flush),
    .i_i_prod (mid_i_prod),
    .i_q_prod (mid_q_prod),
    .i_tlast  (mid_tlast),
    .i_tvalid (mid_tvalid),
    .o_tready (mid_tready),
    .o_tdata  (o_tdata),
    .o_tlast  (o_tlast),
    .o_tvalid (o_tvalid),
    .i_tready (i_tready)
  );

endmodule

`default_nettype wire

// ==== rtl/complex_clip.sv ====
`timescale 1ns/100ps
`default_nettype none

module complex_clip (
  input  wire                    ce_clk,
  input  wire                    i_rst,
  // Input stream of wide products
  input  wire gain_pkg::prod_t   i_i_prod,
  input  wire gain_pkg::prod_t   i_q_prod,
  input  wire                    i_tlast,
  input  wire                    i_tvalid,
  output logic                   o_tready,
  // Output stream of packed samples
  output gain_pkg::iq_t          o_tdata,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  wire                    i_tready
);

  import gain_pkg::*;

  // Saturate a product to the sample range
  function automatic sample_t clip16(input prod_t x);
    sample_t y;
    // Fits when bits 31 down to 15 all match the sign
    if ((&x[31:15]) || !(|x[31:15])) begin
      y = x[15:0];
    end else if (x[31]) begin
      y = 16'sh8000;
    end else begin
      y = 16'sh7FFF;
    end
    return y;
  endfunction

  // Output register empty or being taken
  assign o_tready = !o_tvalid || i_tready;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_tvalid <= 1'b0;
    end else if (o_tready) begin
      o_tvalid <= i_tvalid;
    end
  end

  // I and Q saturate independently
  always_ff @(posedge ce_clk) begin
    if (o_tready) begin
      o_tdata <= {clip16(i_i_prod), clip16(i_q_prod)};
      o_tlast <= i_tlast;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/complex_scaler.sv ====
`timescale 1ns/100ps
`default_nettype none

module complex_scaler (
  input  wire                    ce_clk,
  input  wire                    i_rst,
  input  wire gain_pkg::gain_t   i_gain,
  // Input stream
  input  wire gain_pkg::iq_t     i_tdata,
  input  wire                    i_tlast,
  input  wire                    i_tvalid,
  output logic                   o_tready,
  // Output stream, one product per component
  output gain_pkg::prod_t        o_i_prod,
  output gain_pkg::prod_t        o_q_prod,
  output logic                   o_tlast,
  output logic                   o_tvalid,
  input  wire                    i_tready
);

  import gain_pkg::*;

  // Per stage valid and last, index 0 is stage 1
  logic [SCALER_STAGES-1:0] vld;
  logic [SCALER_STAGES-1:0] lst;

  // Stage 1 sample and gain
  sample_t s1_i;
  sample_t s1_q;
  gain_t   s1_gain;

  // Stage 2 and 3 full products
  prod_t   s2_i;
  prod_t   s2_q;
  prod_t   s3_i;
  prod_t   s3_q;

  // Stage 4 shifted products
  prod_t   s4_i;
  prod_t   s4_q;

  logic    advance;

  ////////////////////
  // Stall control
  ////////////////////

  // Whole pipe moves together when the last slot is free or leaving
  assign advance  = !vld[SCALER_STAGES-1] || i_tready;
  assign o_tready = advance;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[SCALER_STAGES-2:0], i_tvalid};
    end
  end

  always_ff @(posedge ce_clk) begin
    if (advance) begin
      lst <= {lst[SCALER_STAGES-2:0], i_tlast};
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge ce_clk) begin
    if (advance) begin
      // Gain is captured alongside its sample
      s1_i    <= i_tdata[31:16];
      s1_q    <= i_tdata[15:0];
      s1_gain <= i_gain;

      // Signed 16x16 into 32 bits
      s2_i <= s1_i * s1_gain;
      s2_q <= s1_q * s1_gain;

      s3_i <= s2_i;
      s3_q <= s2_q;

      // Arithmetic shift, rounds toward minus infinity
      s4_i <= s3_i >>> GAIN_FRAC_BITS;
      s4_q <= s3_q >>> GAIN_FRAC_BITS;
    end
  end

  assign o_i_prod = s4_i;
  assign o_q_prod = s4_q;
  assign o_tlast  = lst[SCALER_STAGES-1];
  assign o_tvalid = vld[SCALER_STAGES-1];

endmodule

`default_nettype wire

// ==== rtl/gain_settings.sv ====
`timescale 1ns/100ps
`default_nettype none

module gain_settings (
  input  wire                                ce_clk,
  input  wire                                i_rst,
  // Settings bus
  input  wire                                i_set_stb,
  input  wire  [gain_pkg::SR_ADDR_W-1:0]     i_set_addr,
  input  wire  [gain_pkg::SR_DATA_W-1:0]     i_set_data,
  // Readback
  input  wire  [gain_pkg::SR_ADDR_W-1:0]     i_rb_addr,
  output gain_pkg::gain_t                    o_gain,
  output gain_pkg::rb_t                      o_rb_data
);

  import gain_pkg::*;

  ////////////////////
  // Gain register
  ////////////////////

  // Only the low half of the data word is kept
  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_gain <= GAIN_RESET;
    end else if (i_set_stb && (i_set_addr == SR_GAIN)) begin
      o_gain <= i_set_data[15:0];
    end
  end

  ////////////////////
  // Readback mux
  ////////////////////

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      o_rb_data <= '0;
    end else begin
      case (i_rb_addr)
        // Sign extended so the host sees a proper signed value
        RB_GAIN: begin
          o_rb_data <= {{48{o_gain[15]}}, o_gain};
        end
        default: begin
          o_rb_data <= RB_BAD_ADDR;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/gain_pkg.sv ====
`default_nettype none

package gain_pkg;

  ////////////////////
  // Data types
  ////////////////////

  // One I or Q component
  typedef logic signed [15:0] sample_t;

  // I in the upper half, Q in the lower half
  typedef logic [31:0] iq_t;

  // Fixed point gain, 2048 is unity
  typedef logic signed [15:0] gain_t;

  // Scaled product of one component, before clipping
  typedef logic signed [31:0] prod_t;

  // Readback word
  typedef logic [63:0] rb_t;

  ////////////////////
  // Settings bus
  ////////////////////

  localparam int SR_ADDR_W = 8;
  localparam int SR_DATA_W = 32;

  // Lower addresses belong to the shell
  localparam logic [SR_ADDR_W-1:0] SR_USER_BASE = 8'd128;
  localparam logic [SR_ADDR_W-1:0] SR_GAIN      = SR_USER_BASE;

  localparam logic [SR_ADDR_W-1:0] RB_GAIN     = 8'd0;
  localparam rb_t                  RB_BAD_ADDR = 64'h0BAD_C0DE_0BAD_C0DE;

  ////////////////////
  // Arithmetic
  ////////////////////

  localparam int    GAIN_FRAC_BITS = 11;
  localparam int    SCALER_STAGES  = 4;
  localparam gain_t GAIN_RESET     = 16'sd2048;

endpackage

`default_nettype wire
